// File: hw/tankPkg.sv
/*
 * Player tank shared definitions
 * Playfield limits, speed steps, scan codes, command encoding
 * and the packed state records passed between the tank blocks
 */

`default_nettype none

package tankPkg;

    // ----------------------------------------------------------------------
    // Playfield and tank geometry
    // ----------------------------------------------------------------------
    localparam logic [9:0] ScreenXMax  = 10'd639;  // Last pixel column
    localparam logic [9:0] ScreenYMax  = 10'd479;  // Last pixel row
    localparam logic [9:0] TankXCenter = 10'd300;  // Reset position
    localparam logic [9:0] TankYCenter = 10'd250;
    localparam logic [9:0] TankSize    = 10'd10;   // Half width, used for clamping

    // Speeds in pixels per frame at full trig magnitude
    localparam logic [7:0] TankStep   = 8'd6;
    localparam logic [7:0] BulletStep = 8'd12;

    localparam logic [5:0] AngleLast = 6'd44;      // 45 steps of 8 degrees

    // Keyboard scan codes
    localparam logic [7:0] KeyForward = 8'h52;     // Up arrow
    localparam logic [7:0] KeyBack    = 8'h51;     // Down arrow
    localparam logic [7:0] KeyLeft    = 8'h50;     // Left arrow
    localparam logic [7:0] KeyRight   = 8'h4f;     // Right arrow
    localparam logic [7:0] KeyFire    = 8'h2c;     // Space bar

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        cmdNone,
        cmdForward,
        cmdBack,
        cmdLeft,
        cmdRight,
        cmdFire
    } tankCmdE;

    // Sign-magnitude sine and cosine, magnitude scaled to 127
    typedef struct packed {
        logic       sinSign;  // Set when negative
        logic [6:0] sinMag;
        logic       cosSign;
        logic [6:0] cosMag;
    } trigT;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic [5:0] angle;    // Heading index 0..44
    } tankStateT;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       active;   // Bullet in flight
    } bulletStateT;

    // Signed axis delta, step times magnitude over 128, truncated
    function automatic logic signed [11:0] axisDelta(input logic [7:0] step,
                                                     input logic       neg,
                                                     input logic [6:0] mag);
        logic        [14:0] prod;
        logic signed [11:0] m;
        prod = step * mag;
        m    = {4'd0, prod[14:7]};  // Drop 7 fraction bits
        return neg ? -m : m;
    endfunction

endpackage

`default_nettype wire

// File: hw/keyDecoder.sv
/*
 * Key decoder
 * Scans the four keycode bytes once per frame and registers
 * a single command, forward first and fire last
 */

`timescale 1ns/1ps
`default_nettype none

module keyDecoder (
    input  wire logic             Reset,      // Frame clock
    input  wire logic             frame_clk,  // Async reset, active high
    input  wire logic [31:0]      keycode,
    output tankPkg::tankCmdE      cmd
);

    tankPkg::tankCmdE nextCmd;

    // True when any of the four bytes holds the code
    function automatic logic hasCode(input logic [31:0] codes, input logic [7:0] code);
        return (codes[31:24] == code) || (codes[23:16] == code) ||
               (codes[15:8]  == code) || (codes[7:0]   == code);
    endfunction

    // Priority pick
    always_comb
    begin
        if (hasCode(keycode, tankPkg::KeyForward))
            nextCmd = tankPkg::cmdForward;
        else if (hasCode(keycode, tankPkg::KeyBack))
            nextCmd = tankPkg::cmdBack;
        else if (hasCode(keycode, tankPkg::KeyLeft))
            nextCmd = tankPkg::cmdLeft;
        else if (hasCode(keycode, tankPkg::KeyRight))
            nextCmd = tankPkg::cmdRight;
        else if (hasCode(keycode, tankPkg::KeyFire))
            nextCmd = tankPkg::cmdFire;
        else
            nextCmd = tankPkg::cmdNone;  // No game key held
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
            cmd <= tankPkg::cmdNone;
        else
            cmd <= nextCmd;              // One frame of latency
    end

    // Downstream case statements only know these six codes
    cmdLegal: assert property (@(posedge Reset) disable iff (frame_clk)
        cmd inside {tankPkg::cmdNone, tankPkg::cmdForward, tankPkg::cmdBack,
                    tankPkg::cmdLeft, tankPkg::cmdRight, tankPkg::cmdFire});

endmodule

`default_nettype wire

// File: hw/trigTable.sv
/*
 * Heading trig ROM
 * Sine and cosine for 45 headings of 8 degrees, sign-magnitude,
 * magnitude is 127 times the absolute value, rounded
 */

`timescale 1ns/1ps
`default_nettype none

module trigTable (
    input  wire logic [5:0] angle,
    output tankPkg::trigT   trig
);

    // Entries are {sinSign, sinMag, cosSign, cosMag}
    always_comb
    begin
        case (angle)
            // First quadrant, both positive
            6'd0:  trig = {1'b0, 7'd0,   1'b0, 7'd127};  // 0 deg
            6'd1:  trig = {1'b0, 7'd18,  1'b0, 7'd126};
            6'd2:  trig = {1'b0, 7'd35,  1'b0, 7'd122};
            6'd3:  trig = {1'b0, 7'd52,  1'b0, 7'd116};
            6'd4:  trig = {1'b0, 7'd67,  1'b0, 7'd108};
            6'd5:  trig = {1'b0, 7'd82,  1'b0, 7'd97};
            6'd6:  trig = {1'b0, 7'd94,  1'b0, 7'd85};
            6'd7:  trig = {1'b0, 7'd105, 1'b0, 7'd71};
            6'd8:  trig = {1'b0, 7'd114, 1'b0, 7'd56};
            6'd9:  trig = {1'b0, 7'd121, 1'b0, 7'd39};
            6'd10: trig = {1'b0, 7'd125, 1'b0, 7'd22};
            6'd11: trig = {1'b0, 7'd127, 1'b0, 7'd4};    // 88 deg
            // Second quadrant, cosine negative
            6'd12: trig = {1'b0, 7'd126, 1'b1, 7'd13};
            6'd13: trig = {1'b0, 7'd123, 1'b1, 7'd31};
            6'd14: trig = {1'b0, 7'd118, 1'b1, 7'd48};
            6'd15: trig = {1'b0, 7'd110, 1'b1, 7'd64};   // 63.5 rounds up
            6'd16: trig = {1'b0, 7'd100, 1'b1, 7'd78};
            6'd17: trig = {1'b0, 7'd88,  1'b1, 7'd91};
            6'd18: trig = {1'b0, 7'd75,  1'b1, 7'd103};
            6'd19: trig = {1'b0, 7'd60,  1'b1, 7'd112};
            6'd20: trig = {1'b0, 7'd43,  1'b1, 7'd119};
            6'd21: trig = {1'b0, 7'd26,  1'b1, 7'd124};
            6'd22: trig = {1'b0, 7'd9,   1'b1, 7'd127};  // 176 deg
            // Third quadrant, both negative
            6'd23: trig = {1'b1, 7'd9,   1'b1, 7'd127};
            6'd24: trig = {1'b1, 7'd26,  1'b1, 7'd124};
            6'd25: trig = {1'b1, 7'd43,  1'b1, 7'd119};
            6'd26: trig = {1'b1, 7'd60,  1'b1, 7'd112};
            6'd27: trig = {1'b1, 7'd75,  1'b1, 7'd103};
            6'd28: trig = {1'b1, 7'd88,  1'b1, 7'd91};
            6'd29: trig = {1'b1, 7'd100, 1'b1, 7'd78};
            6'd30: trig = {1'b1, 7'd110, 1'b1, 7'd64};
            6'd31: trig = {1'b1, 7'd118, 1'b1, 7'd48};
            6'd32: trig = {1'b1, 7'd123, 1'b1, 7'd31};
            6'd33: trig = {1'b1, 7'd126, 1'b1, 7'd13};
            // Fourth quadrant, sine negative
            6'd34: trig = {1'b1, 7'd127, 1'b0, 7'd4};    // 272 deg
            6'd35: trig = {1'b1, 7'd125, 1'b0, 7'd22};
            6'd36: trig = {1'b1, 7'd121, 1'b0, 7'd39};
            6'd37: trig = {1'b1, 7'd114, 1'b0, 7'd56};
            6'd38: trig = {1'b1, 7'd105, 1'b0, 7'd71};
            6'd39: trig = {1'b1, 7'd94,  1'b0, 7'd85};
            6'd40: trig = {1'b1, 7'd82,  1'b0, 7'd97};
            6'd41: trig = {1'b1, 7'd67,  1'b0, 7'd108};
            6'd42: trig = {1'b1, 7'd52,  1'b0, 7'd116};
            6'd43: trig = {1'b1, 7'd35,  1'b0, 7'd122};
            6'd44: trig = {1'b1, 7'd18,  1'b0, 7'd126};  // 352 deg
            default: trig = '0;                          // Past AngleLast
        endcase
    end

endmodule

`default_nettype wire

// File: hw/tankMotion.sv
/*
 * Tank motion
 * Heading and position registers, one update per frame
 * Forward and back move along the heading, left and right
 * step the heading with wrap, position clamped to the playfield
 */

`timescale 1ns/1ps
`default_nettype none

module tankMotion (
    input  wire logic              Reset,      // Frame clock
    input  wire logic              frame_clk,  // Async reset, active high
    input  wire tankPkg::tankCmdE  cmd,
    input  wire tankPkg::trigT     trig,
    output tankPkg::tankStateT     tank
);

    logic signed [11:0] dX, dY;          // Forward deltas
    logic signed [11:0] moveX, moveY;    // Deltas for this command
    logic signed [11:0] nextX, nextY;    // Unclamped position
    logic        [9:0]  clampX, clampY;
    logic        [5:0]  nextAngle;

    // Limit a signed coordinate to lo..hi
    function automatic logic [9:0] clampAxis(input logic signed [11:0] v,
                                             input logic        [9:0]  lo,
                                             input logic        [9:0]  hi);
        if (v < $signed({2'b00, lo}))
            return lo;
        else if (v > $signed({2'b00, hi}))
            return hi;
        else
            return v[9:0];
    endfunction

    // ----------------------------------------------------------------------
    // Position step
    // ----------------------------------------------------------------------
    always_comb
    begin
        // Screen y grows downward so positive sine moves up
        dX = tankPkg::axisDelta(tankPkg::TankStep, trig.cosSign, trig.cosMag);
        dY = tankPkg::axisDelta(tankPkg::TankStep, ~trig.sinSign, trig.sinMag);

        case (cmd)
            tankPkg::cmdForward:
            begin
                moveX = dX;
                moveY = dY;
            end
            tankPkg::cmdBack:
            begin
                moveX = -dX;         // Reverse along heading
                moveY = -dY;
            end
            default:
            begin
                moveX = '0;
                moveY = '0;
            end
        endcase

        nextX  = $signed({2'b00, tank.x}) + moveX;
        nextY  = $signed({2'b00, tank.y}) + moveY;
        clampX = clampAxis(nextX, tankPkg::TankSize, tankPkg::ScreenXMax - tankPkg::TankSize);
        clampY = clampAxis(nextY, tankPkg::TankSize, tankPkg::ScreenYMax - tankPkg::TankSize);
    end

    // ----------------------------------------------------------------------
    // Heading step
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (cmd)
            tankPkg::cmdLeft:                // Counter clockwise
                nextAngle = (tank.angle == tankPkg::AngleLast) ? 6'd0 : tank.angle + 6'd1;
            tankPkg::cmdRight:               // Clockwise
                nextAngle = (tank.angle == 6'd0) ? tankPkg::AngleLast : tank.angle - 6'd1;
            default:
                nextAngle = tank.angle;
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            tank.x     <= tankPkg::TankXCenter;
            tank.y     <= tankPkg::TankYCenter;
            tank.angle <= 6'd0;              // Facing right
        end
        else
        begin
            tank.x     <= clampX;
            tank.y     <= clampY;
            tank.angle <= nextAngle;
        end
    end

    // Trig ROM returns zero past 44, the tank would stall
    angleInRange: assert property (@(posedge Reset) disable iff (frame_clk)
        tank.angle <= tankPkg::AngleLast);

    // Bullet launch point relies on the tank staying on screen
    tankInBounds: assert property (@(posedge Reset) disable iff (frame_clk)
        (tank.x >= tankPkg::TankSize) &&
        (tank.x <= tankPkg::ScreenXMax - tankPkg::TankSize) &&
        (tank.y >= tankPkg::TankSize) &&
        (tank.y <= tankPkg::ScreenYMax - tankPkg::TankSize));

endmodule

`default_nettype wire

// File: hw/bulletUnit.sv
/*
 * Bullet unit
 * One bullet per press of fire, launched from the tank position
 * along the current heading, moves every frame, dies off screen
 */

`timescale 1ns/1ps
`default_nettype none

module bulletUnit (
    input  wire logic               Reset,      // Frame clock
    input  wire logic               frame_clk,  // Async reset, active high
    input  wire tankPkg::tankCmdE   cmd,
    input  wire tankPkg::trigT      trig,
    input  wire tankPkg::tankStateT tank,
    output tankPkg::bulletStateT    bullet,
    output logic                    shootBullet // Launch pulse
);

    tankPkg::tankCmdE   prevCmd;                   // For fire edge detect
    logic signed [11:0] velX, velY;                // Latched at launch
    logic signed [11:0] launchVelX, launchVelY;
    logic signed [11:0] nextX, nextY;
    logic               launch;
    logic               offScreen;

    always_comb
    begin
        // Same axis convention as the tank
        launchVelX = tankPkg::axisDelta(tankPkg::BulletStep, trig.cosSign, trig.cosMag);
        launchVelY = tankPkg::axisDelta(tankPkg::BulletStep, ~trig.sinSign, trig.sinMag);

        // New fire press with no bullet in flight
        launch = (cmd == tankPkg::cmdFire) && !bullet.active &&
                 (prevCmd != tankPkg::cmdFire);

        nextX = $signed({2'b00, bullet.x}) + velX;
        nextY = $signed({2'b00, bullet.y}) + velY;

        offScreen = (nextX < 12'sd0) || (nextX > $signed({2'b00, tankPkg::ScreenXMax})) ||
                    (nextY < 12'sd0) || (nextY > $signed({2'b00, tankPkg::ScreenYMax}));
    end

    // ----------------------------------------------------------------------
    // Velocity latch
    // ----------------------------------------------------------------------
    always_ff @(posedge Reset)
    begin
        if (launch)
        begin
            velX <= launchVelX;
            velY <= launchVelY;
        end
    end

    // ----------------------------------------------------------------------
    // Bullet state
    // ----------------------------------------------------------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            prevCmd     <= tankPkg::cmdNone;
            shootBullet <= 1'b0;
            bullet      <= '0;
        end
        else
        begin
            prevCmd     <= cmd;
            shootBullet <= launch;           // High for the launch frame only
            if (launch)
            begin
                bullet.x      <= tank.x;     // Start at tank center
                bullet.y      <= tank.y;
                bullet.active <= 1'b1;
            end
            else if (bullet.active)
            begin
                if (offScreen)
                    bullet.active <= 1'b0;   // Leaves screen, position kept
                else
                begin
                    bullet.x <= nextX[9:0];
                    bullet.y <= nextY[9:0];
                end
            end
        end
    end

    // A live bullet is always drawable
    bulletOnScreen: assert property (@(posedge Reset) disable iff (frame_clk)
        bullet.active |-> (bullet.x <= tankPkg::ScreenXMax) &&
                          (bullet.y <= tankPkg::ScreenYMax));

    // Launch needs the bullet idle, so never two frames in a row
    singleShot: assert property (@(posedge Reset) disable iff (frame_clk)
        shootBullet |=> !shootBullet);

endmodule

`default_nettype wire

// File: hw/tankTop.sv
/*
 * Player tank top level
 * Key decoder feeds tank motion and the bullet unit
 * Trig ROM is indexed by the live tank heading
 */

`timescale 1ns/1ps
`default_nettype none

module tankTop (
    input  wire logic            Reset,      // Frame clock, one edge per frame
    input  wire logic            frame_clk,  // Async reset, active high
    input  wire logic [31:0]     keycode,    // Four scan codes
    output tankPkg::tankStateT   tank,
    output tankPkg::bulletStateT bullet,
    output logic                 shootBullet
);

    tankPkg::tankCmdE cmd;   // Registered command
    tankPkg::trigT    trig;  // Heading sine and cosine

    keyDecoder keyDecoder_i (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .cmd       (cmd)
    );

    // Combinational, same frame as the heading
    trigTable trigTable_i (
        .angle (tank.angle),
        .trig  (trig)
    );

    tankMotion tankMotion_i (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .cmd       (cmd),
        .trig      (trig),
        .tank      (tank)
    );

    bulletUnit bulletUnit_i (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .cmd         (cmd),
        .trig        (trig),
        .tank        (tank),
        .bullet      (bullet),
        .shootBullet (shootBullet)
    );

endmodule

`default_nettype wire

// File: verification/tankTb.sv
/*
 * Player tank testbench
 * Replays keycode holds from a stimulus file against the tank top level
 * Checks position, heading, bullet state and launch pulses per test
 */

`timescale 1ns/1ps
`default_nettype none

module tankTb;

    logic                 Reset;         // Frame clock
    logic                 frame_clk;     // Reset, active high
    logic [31:0]          keycode;
    tankPkg::tankStateT   tank;
    tankPkg::bulletStateT bullet;
    logic                 shootBullet;

    int errorCount;                      // Failed checks, whole run
    int testErrors;                      // Failed checks, current test
    int testsRun;
    int testsFailed;
    int pulseCount;                      // Launch pulses, current test

    tankTop tankTop_i (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .keycode     (keycode),
        .tank        (tank),
        .bullet      (bullet),
        .shootBullet (shootBullet)
    );

    always #5 Reset = ~Reset;            // 10 ns per frame

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            $display("mismatch at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            testErrors++;
        end
    endtask

    // Empty bytes get a random code that is no game key
    function automatic logic [31:0] fillKeycode(input logic [31:0] keys);
        logic [31:0] filled;
        logic [31:0] rnd;
        logic [7:0]  code;
        filled = keys;
        for (int i = 0; i < 4; i++)
        begin
            if (keys[i*8 +: 8] == 8'h00)
            begin
                rnd  = $urandom;
                code = rnd[7:0];
                if (code inside {8'h52, 8'h51, 8'h50, 8'h4f, 8'h2c})
                    code = code ^ 8'h80;     // Moves it off the key set
                filled[i*8 +: 8] = code;
            end
        end
        return filled;
    endfunction

    // One frame, sampled 1 ns after the edge
    task automatic nextFrame(input int launchX, input int launchY);
        @(posedge Reset);
        #1;
        if (shootBullet)
        begin
            pulseCount++;
            checkValue("bullet.x at launch", launchX, bullet.x);  // Starts on the tank
            checkValue("bullet.y at launch", launchY, bullet.y);
        end
    endtask

    task automatic waitBulletGone(input int launchX, input int launchY);
        int frames;
        frames = 0;
        while (bullet.active && frames < 200)
        begin
            nextFrame(launchX, launchY);
            frames++;
        end
        if (bullet.active)
        begin
            $display("timeout: bullet still in flight after %0d frames", frames);
            testErrors++;
        end
    endtask

    task automatic runTest(input int num, input logic [31:0] keys, input int hold,
                           input int expX, input int expY, input int expAngle,
                           input int expActive, input int expPulses, input int waitGone);
        testErrors = 0;
        pulseCount = 0;
        keycode = fillKeycode(keys);
        for (int i = 0; i < hold; i++)
            nextFrame(expX, expY);
        keycode = fillKeycode(32'h0);        // Keys released
        nextFrame(expX, expY);               // Last command reaches the tank
        nextFrame(expX, expY);
        checkValue("tank.x", expX, tank.x);
        checkValue("tank.y", expY, tank.y);
        checkValue("tank.angle", expAngle, tank.angle);
        checkValue("bullet.active", expActive, bullet.active);
        if (waitGone != 0)
            waitBulletGone(expX, expY);
        checkValue("shootBullet pulses", expPulses, pulseCount);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        errorCount += testErrors;
        $display("test %0d keys %h hold %0d: %0d errors", num, keys, hold, testErrors);
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin : mainSeq
        int          fd;
        int          n;
        string       line;
        int          num, hold, expX, expY, expAngle, expActive, expPulses, waitGone;
        logic [31:0] keys;

        void'($urandom(32'h32ba));
        Reset       = 1'b0;
        frame_clk   = 1'b1;
        keycode     = 32'h0;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        pulseCount  = 0;

        for (int i = 0; i < 5; i++)          // Reset held for 5 frames
            @(posedge Reset);
        #1;
        frame_clk = 1'b0;

        fd = $fopen("verification/tankStim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file verification/tankStim.txt");
            errorCount++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0)
                begin
                    // Comment lines fail the first field
                    n = $sscanf(line, "%d %h %d %d %d %d %d %d %d", num, keys, hold,
                                expX, expY, expAngle, expActive, expPulses, waitGone);
                    if (n == 9)
                        runTest(num, keys, hold, expX, expY, expAngle,
                                expActive, expPulses, waitGone);
                end
            end
            $fclose(fd);
        end

        if (testsRun == 0)
        begin
            $display("no tests were read from the stimulus file");
            errorCount++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/tankStim.txt
# test keycode(hex, 00 bytes get random filler) hold expX expY expAngle
# expActive expPulses waitGone, checked after hold plus 2 frames
1 00000000 1 300 250 0 0 0 0
2 00000050 46 300 250 1 0 0 0
3 0000004f 2 300 250 44 0 0 0
4 00000050 1 300 250 0 0 0 0
5 00000052 3 315 250 0 0 0 0
6 00000051 3 300 250 0 0 0 0
7 00000050 11 300 250 11 0 0 0
8 00000052 4 300 230 11 0 0 0
9 00000051 4 300 250 11 0 0 0
10 00000050 11 300 250 22 0 0 0
11 00000052 2 290 250 22 0 0 0
12 00000051 2 300 250 22 0 0 0
13 0000004f 22 300 250 0 0 0 0
14 00000052 70 629 250 0 0 0 0
15 00000051 10 579 250 0 0 0 0
16 0000522c 2 589 250 0 0 0 0
17 00504f00 3 589 250 3 0 0 0
18 0000004f 3 589 250 0 0 0 0
19 0000002c 1 589 250 0 1 1 0
20 00002c00 2 589 250 0 0 0 0
21 00000050 11 589 250 11 0 0 0
22 2c000000 1 589 250 11 1 1 1
23 0000002c 1 589 250 11 1 1 1

// File: filelist.f
hw/tankPkg.sv
hw/keyDecoder.sv
hw/trigTable.sv
hw/tankMotion.sv
hw/bulletUnit.sv
hw/tankTop.sv
verification/tankTb.sv
